//--- hw/mem_stage_cfg.svh
// Fixed widths, CSR addresses and CSR contents; include wherever these constants are needed.
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Register and data bus width.
`define MEM_XLEN 32

// Machine CSR addresses.
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305
`define CSR_MISA     12'h301
`define CSR_MHARTID  12'hF14

// Read-only CSR contents: RV32I, single hart.
`define MISA_VALUE   32'h4000_0100
`define HART_ID      32'h0000_0000

// Trap vector after reset.
`define MTVEC_RESET  32'h0000_0000

`endif

//--- hw/mem_stage_pkg.sv
// Types shared by the memory stage blocks; modules pull them in with a wildcard import.
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

    // Major opcode field, insn[6:2].
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_STORE  = 5'b01000,
        OP_SYSTEM = 5'b11100,
        OP_OTHER  = 5'b11111
    } rv_opcode_t;

    // Matches funct3[1:0] of loads and stores.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_BAD  = 2'b11
    } access_size_t;

    // Matches funct3[1:0] of the CSR instructions.
    typedef enum logic [1:0] {
        CSR_NONE  = 2'b00,
        CSR_WRITE = 2'b01,
        CSR_SET   = 2'b10,
        CSR_CLEAR = 2'b11
    } csr_op_t;

    typedef enum logic [1:0] {
        KIND_PASS  = 2'b00,
        KIND_LOAD  = 2'b01,
        KIND_STORE = 2'b10,
        KIND_CSR   = 2'b11
    } mem_kind_t;

    // Causes raised here; upstream codes travel as raw values.
    typedef enum logic [3:0] {
        CAUSE_ILLEGAL     = 4'd2,
        CAUSE_LOAD_ALIGN  = 4'd4,
        CAUSE_STORE_ALIGN = 4'd6
    } trap_cause_t;

    typedef struct packed {
        mem_kind_t             kind;
        access_size_t          size;
        logic                  is_signed;
        csr_op_t               csr_op;
        logic [11:0]           csr_addr;
        logic [`MEM_XLEN-1:0]  csr_mask;
        logic                  csr_write;
        logic [`MEM_XLEN-1:0]  addr;
        logic [`MEM_XLEN-1:0]  wdata;
        logic [31:1]           pc;
        logic [31:0]           insn;
        logic                  use_rd;
        logic                  trap;
        logic [3:0]            cause;
    } mem_op_t;

endpackage

//--- hw/mem_stage_ifc.sv
// Data bus and CSR bus interfaces that connect the memory stage blocks.
`include "mem_stage_cfg.svh"

interface data_bus_if;
    // Word address, the two low bits are carried by the lane mask.
    logic [29:0]           addr;
    logic                  re;
    logic [3:0]            we;
    logic [`MEM_XLEN-1:0]  wdata;
    // Valid the cycle after ready completes a read.
    logic [`MEM_XLEN-1:0]  rdata;
    logic                  ready;

    modport master (
        output addr, re, we, wdata,
        input  rdata, ready
    );

    modport mon (
        input addr, re, we, wdata, rdata, ready
    );
endinterface

interface csr_bus_if import mem_stage_pkg::*; ();
    logic [11:0]           addr;
    csr_op_t               op;
    logic [`MEM_XLEN-1:0]  mask;
    logic                  re;
    logic                  we;
    // Combinational answer for the current address.
    logic [`MEM_XLEN-1:0]  rdata;
    logic                  exists;
    logic                  rdonly;

    modport client (
        output addr, op, mask, re, we,
        input  rdata, exists, rdonly
    );

    modport server (
        input  addr, op, mask, re, we,
        output rdata, exists, rdonly
    );
endinterface

//--- hw/mem_decode.sv
// Stage barrier register with instruction decode; drives the CSR request of the held item.
`include "mem_stage_cfg.svh"

module mem_decode
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:1]           in_pc,
    input  logic [31:0]           in_insn,
    input  logic                  in_use_rd,
    input  logic [`MEM_XLEN-1:0]  in_rs1_val,
    input  logic [`MEM_XLEN-1:0]  in_rs2_val,
    input  logic                  in_trap,
    input  logic [3:0]            in_cause,
    input  logic                  advance,
    output mem_op_t               op,
    output logic                  op_valid,
    csr_bus_if.client             csr
);
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic        size_ok;
    logic        csr_req;
    rv_opcode_t  opcode;
    mem_op_t     dec;

    assign funct3    = in_insn[14:12];
    assign rs1_field = in_insn[19:15];

    // LWU, LD and wide or unsigned stores do not exist on RV32.
    assign size_ok = (funct3[1:0] != 2'b11) && (funct3 != 3'b110)
                  && !(opcode == OP_STORE && funct3[2]);

    always_comb begin
        case (in_insn[6:2])
            OP_LOAD:   opcode = OP_LOAD;
            OP_STORE:  opcode = OP_STORE;
            OP_SYSTEM: opcode = OP_SYSTEM;
            default:   opcode = OP_OTHER;
        endcase
    end

    always_comb begin
        dec           = '0;
        dec.size      = size_ok ? access_size_t'(funct3[1:0]) : SIZE_BAD;
        dec.is_signed = !funct3[2];
        dec.csr_addr  = in_insn[31:20];
        // Immediate forms take the zero-extended rs1 field.
        dec.csr_mask  = funct3[2] ? {{(`MEM_XLEN-5){1'b0}}, rs1_field} : in_rs1_val;
        // Set and clear with a zero source are read-only accesses.
        dec.csr_write = (funct3[1:0] == 2'b01) || (rs1_field != 5'd0);
        dec.addr      = in_rs1_val;
        dec.wdata     = in_rs2_val;
        dec.pc        = in_pc;
        dec.insn      = in_insn;
        dec.use_rd    = in_use_rd;
        dec.trap      = in_trap;
        dec.cause     = in_cause;
        case (opcode)
            OP_LOAD:   dec.kind = size_ok ? KIND_LOAD : KIND_PASS;
            OP_STORE:  dec.kind = size_ok ? KIND_STORE : KIND_PASS;
            OP_SYSTEM: dec.kind = (funct3[1:0] != 2'b00) ? KIND_CSR : KIND_PASS;
            default:   dec.kind = KIND_PASS;
        endcase
        dec.csr_op = (dec.kind == KIND_CSR) ? csr_op_t'(funct3[1:0]) : CSR_NONE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (advance) begin
            op_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op <= dec;
        end
    end

    // No CSR side effects for a trapped item.
    assign csr_req  = op_valid && (op.kind == KIND_CSR) && !op.trap;
    assign csr.addr = op.csr_addr;
    assign csr.op   = op.csr_op;
    assign csr.mask = op.csr_mask;
    assign csr.re   = csr_req;
    assign csr.we   = csr_req && op.csr_write;
endmodule

//--- hw/mem_access.sv
// Load and store execution on the data bus: lane steering, alignment check and load extension.
`include "mem_stage_cfg.svh"

module mem_access
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_op_t               op,
    input  logic                  op_valid,
    output logic                  misalign,
    output logic [`MEM_XLEN-1:0]  load_data,
    output logic                  done,
    data_bus_if.master            bus
);
    logic                  is_mem;
    logic                  aligned;
    logic                  req;
    logic [3:0]            lanes;
    logic                  rsp_valid;
    access_size_t          rsp_size;
    logic                  rsp_signed;
    logic [1:0]            rsp_lo;
    logic [7:0]            rsp_byte;
    logic [15:0]           rsp_half;

    assign is_mem = op_valid && (op.kind == KIND_LOAD || op.kind == KIND_STORE);

    // Alignment and lane mask from size and low address bits.
    always_comb begin
        case (op.size)
            SIZE_BYTE: begin
                aligned  = 1'b1;
                lanes    = 4'b0001 << op.addr[1:0];
                bus.wdata = {4{op.wdata[7:0]}};
            end
            SIZE_HALF: begin
                aligned  = !op.addr[0];
                lanes    = op.addr[1] ? 4'b1100 : 4'b0011;
                bus.wdata = {2{op.wdata[15:0]}};
            end
            SIZE_WORD: begin
                aligned  = (op.addr[1:0] == 2'b00);
                lanes    = 4'b1111;
                bus.wdata = op.wdata;
            end
            default: begin
                aligned  = 1'b0;
                lanes    = 4'b0000;
                bus.wdata = op.wdata;
            end
        endcase
    end

    assign misalign = is_mem && !aligned;
    assign req      = is_mem && aligned && !op.trap;

    // The decode register holds the item, so the request is stable while stalled.
    assign bus.addr = op.addr[31:2];
    assign bus.re   = req && (op.kind == KIND_LOAD);
    assign bus.we   = (req && op.kind == KIND_STORE) ? lanes : 4'b0000;

    assign done = !req || bus.ready;

    // Response state for the read completing this cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= bus.re && bus.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.re && bus.ready) begin
            rsp_size   <= op.size;
            rsp_signed <= op.is_signed;
            rsp_lo     <= op.addr[1:0];
        end
    end

    // Lane select.
    always_comb begin
        case (rsp_lo)
            2'b00:   rsp_byte = bus.rdata[7:0];
            2'b01:   rsp_byte = bus.rdata[15:8];
            2'b10:   rsp_byte = bus.rdata[23:16];
            default: rsp_byte = bus.rdata[31:24];
        endcase
        rsp_half = rsp_lo[1] ? bus.rdata[31:16] : bus.rdata[15:0];
    end

    // Sign or zero extension.
    always_comb begin
        if (!rsp_valid) begin
            load_data = '0;
        end else begin
            case (rsp_size)
                SIZE_BYTE: load_data = {{24{rsp_signed && rsp_byte[7]}}, rsp_byte};
                SIZE_HALF: load_data = {{16{rsp_signed && rsp_half[15]}}, rsp_half};
                SIZE_WORD: load_data = bus.rdata;
                default:   load_data = '0;
            endcase
        end
    end
endmodule

//--- hw/csr_file.sv
// Machine CSR file with combinational read and read-modify-write on commit.
`include "mem_stage_cfg.svh"

module csr_file
    import mem_stage_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       commit,
    csr_bus_if.server  csr
);
    logic [`MEM_XLEN-1:0] mscratch;
    logic [`MEM_XLEN-1:0] mtvec;
    logic [`MEM_XLEN-1:0] new_val;
    logic                 wr_en;

    // Address decode.
    always_comb begin
        csr.exists = 1'b1;
        csr.rdonly = 1'b0;
        case (csr.addr)
            `CSR_MSCRATCH: csr.rdata = mscratch;
            `CSR_MTVEC:    csr.rdata = mtvec;
            `CSR_MISA: begin
                csr.rdata  = `MISA_VALUE;
                csr.rdonly = 1'b1;
            end
            `CSR_MHARTID: begin
                csr.rdata  = `HART_ID;
                csr.rdonly = 1'b1;
            end
            default: begin
                csr.rdata  = '0;
                csr.exists = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (csr.op)
            CSR_WRITE: new_val = csr.mask;
            CSR_SET:   new_val = csr.rdata | csr.mask;
            CSR_CLEAR: new_val = csr.rdata & ~csr.mask;
            default:   new_val = csr.rdata;
        endcase
    end

    // Illegal writes leave the file untouched.
    assign wr_en = commit && csr.re && csr.we && csr.exists && !csr.rdonly;

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            mtvec    <= `MTVEC_RESET;
        end else if (wr_en) begin
            if (csr.addr == `CSR_MSCRATCH) begin
                mscratch <= new_val;
            end
            if (csr.addr == `CSR_MTVEC) begin
                mtvec <= new_val;
            end
        end
    end
endmodule

//--- hw/mem_result.sv
// Result register of the memory stage: trap priority, write-back select and output valid.
`include "mem_stage_cfg.svh"

module mem_result
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  mem_op_t               op,
    input  logic                  op_valid,
    input  logic                  misalign,
    input  logic [`MEM_XLEN-1:0]  load_data,
    input  logic                  done,
    output logic                  advance,
    output logic                  out_valid,
    output logic [31:1]           out_pc,
    output logic [31:0]           out_insn,
    output logic                  out_use_rd,
    output logic [`MEM_XLEN-1:0]  out_rd_val,
    output logic                  out_trap,
    output logic [3:0]            out_cause,
    output logic                  busy,
    csr_bus_if.client             csr
);
    logic                 csr_illegal;
    logic                 trap;
    logic [3:0]           cause;
    logic [`MEM_XLEN-1:0] value;
    logic                 load_q;
    logic [`MEM_XLEN-1:0] value_q;

    assign advance = done;
    assign busy    = !done;

    assign csr_illegal = (op.kind == KIND_CSR)
                      && (!csr.exists || (op.csr_write && csr.rdonly));

    // Upstream trap wins, then alignment, then CSR access.
    always_comb begin
        trap  = 1'b1;
        cause = op.cause;
        if (op.trap) begin
            cause = op.cause;
        end else if (misalign) begin
            cause = (op.kind == KIND_STORE) ? CAUSE_STORE_ALIGN : CAUSE_LOAD_ALIGN;
        end else if (csr_illegal) begin
            cause = CAUSE_ILLEGAL;
        end else begin
            trap = 1'b0;
        end
    end

    // CSR instructions return the old value.
    assign value = (op.kind == KIND_CSR) ? csr.rdata : op.addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= advance && op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && op_valid) begin
            out_pc     <= op.pc;
            out_insn   <= op.insn;
            out_use_rd <= op.use_rd;
            out_trap   <= trap;
            out_cause  <= cause;
            value_q    <= value;
            load_q     <= (op.kind == KIND_LOAD) && !trap;
        end
    end

    // Load data arrives in the output cycle itself.
    assign out_rd_val = load_q ? load_data : value_q;
endmodule

//--- hw/mem_stage_top.sv
// Memory stage top level; plain ports for the pipeline and the external data bus.
`include "mem_stage_cfg.svh"

module mem_stage_top
    import mem_stage_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:1]           in_pc,
    input  logic [31:0]           in_insn,
    input  logic                  in_use_rd,
    input  logic [`MEM_XLEN-1:0]  in_rs1_val,
    input  logic [`MEM_XLEN-1:0]  in_rs2_val,
    input  logic                  in_trap,
    input  logic [3:0]            in_cause,
    output logic                  out_valid,
    output logic [31:1]           out_pc,
    output logic [31:0]           out_insn,
    output logic                  out_use_rd,
    output logic [`MEM_XLEN-1:0]  out_rd_val,
    output logic                  out_trap,
    output logic [3:0]            out_cause,
    output logic                  busy,
    output logic [29:0]           dbus_addr,
    output logic                  dbus_re,
    output logic [3:0]            dbus_we,
    output logic [`MEM_XLEN-1:0]  dbus_wdata,
    input  logic [`MEM_XLEN-1:0]  dbus_rdata,
    input  logic                  dbus_ready
);
    mem_op_t              op;
    logic                 op_valid;
    logic                 advance;
    logic                 misalign;
    logic                 done;
    logic [`MEM_XLEN-1:0] load_data;

    data_bus_if dbus ();
    csr_bus_if  csr_bus ();

    assign dbus_addr  = dbus.addr;
    assign dbus_re    = dbus.re;
    assign dbus_we    = dbus.we;
    assign dbus_wdata = dbus.wdata;
    assign dbus.rdata = dbus_rdata;
    assign dbus.ready = dbus_ready;

    mem_decode u_decode (
        .clk, .rst, .in_valid, .in_pc, .in_insn, .in_use_rd,
        .in_rs1_val, .in_rs2_val, .in_trap, .in_cause,
        .advance, .op, .op_valid, .csr(csr_bus.client)
    );

    mem_access u_access (
        .clk, .rst, .op, .op_valid, .misalign, .load_data, .done,
        .bus(dbus.master)
    );

    // CSR writes land on the edge that moves the item into the result register.
    csr_file u_csr (
        .clk, .rst, .commit(advance), .csr(csr_bus.server)
    );

    mem_result u_result (
        .clk, .rst, .op, .op_valid, .misalign, .load_data, .done,
        .advance, .out_valid, .out_pc, .out_insn, .out_use_rd, .out_rd_val,
        .out_trap, .out_cause, .busy, .csr(csr_bus.client)
    );
endmodule

//--- verif/mem_stage_checker.sv
// Protocol assertions on the data bus and output valid; bound into the memory stage top level.
module mem_stage_checker (
    input logic        clk,
    input logic        rst,
    input logic [29:0] dbus_addr,
    input logic        dbus_re,
    input logic [3:0]  dbus_we,
    input logic [31:0] dbus_wdata,
    input logic        dbus_ready,
    input logic        out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // A stalled request holds until ready completes it.
    request_held: assert property (@(posedge clk) disable iff (rst)
        (dbus_re || dbus_we != 4'b0000) && !dbus_ready |=>
            $stable(dbus_addr) && $stable(dbus_re) && $stable(dbus_we) && $stable(dbus_wdata))
        else begin
            fail_count++;
            $error("bus request changed while stalled");
        end

    // Read and write never share a cycle.
    read_write_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dbus_re && dbus_we != 4'b0000))
        else begin
            fail_count++;
            $error("read and write requested together");
        end

    reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end
endmodule

bind mem_stage_top mem_stage_checker u_checker (
    .clk, .rst, .dbus_addr, .dbus_re, .dbus_we, .dbus_wdata, .dbus_ready, .out_valid
);

//--- verif/mem_stage_tb.sv
// Testbench for the memory stage; replays the pattern file against a data bus memory model.
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    NUM_TESTS    = 34;
    localparam int    NUM_COLS     = 9;
    localparam string PATTERN_FILE = "verif/mem_stage_patterns.hex";

    // Pattern columns.
    localparam int COL_INSN      = 0;
    localparam int COL_PC        = 1;
    localparam int COL_RS1       = 2;
    localparam int COL_RS2       = 3;
    localparam int COL_TRAP      = 4;
    localparam int COL_CAUSE     = 5;
    localparam int COL_RD        = 6;
    localparam int COL_EXP_TRAP  = 7;
    localparam int COL_EXP_CAUSE = 8;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:1] in_pc;
    logic [31:0] in_insn;
    logic        in_use_rd;
    logic [31:0] in_rs1_val;
    logic [31:0] in_rs2_val;
    logic        in_trap;
    logic [3:0]  in_cause;
    logic        out_valid;
    logic [31:1] out_pc;
    logic [31:0] out_insn;
    logic        out_use_rd;
    logic [31:0] out_rd_val;
    logic        out_trap;
    logic [3:0]  out_cause;
    logic        busy;
    logic [29:0] dbus_addr;
    logic        dbus_re;
    logic [3:0]  dbus_we;
    logic [31:0] dbus_wdata;
    logic [31:0] dbus_rdata;
    logic        dbus_ready = 1'b0;

    logic [31:0] pat [0:NUM_TESTS*NUM_COLS-1];
    logic [31:0] mem [0:63];
    logic [31:0] rdata_q = '0;
    logic [15:0] lfsr = 16'd30572;

    int results_seen = 0;
    int passed = 0;
    int failed = 0;
    int errors = 0;
    int bus_count = 0;

    mem_stage_top u_dut (.*);

    always #10 clk = ~clk;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    function automatic logic [31:0] pat_field(input int idx, input int col);
        return pat[idx * NUM_COLS + col];
    endfunction

    // Stores carry no destination; other instructions write rd unless it is x0.
    function automatic logic writes_rd(input logic [31:0] insn);
        return (insn[6:0] != 7'h23) && (insn[11:7] != 5'd0);
    endfunction

    // Loads and stores without a trap make exactly one bus request each.
    function automatic int expected_requests();
        int count;
        int t;
        logic [31:0] insn;
        logic [6:0]  opc;
        count = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            insn = pat_field(t, COL_INSN);
            opc  = insn[6:0];
            if ((opc == 7'h03 || opc == 7'h23) && pat_field(t, COL_EXP_TRAP) == 32'd0) begin
                count++;
            end
        end
        return count;
    endfunction

    task automatic drive_item(input int idx);
        logic [31:0] pc;
        logic [31:0] cause_word;
        pc         = pat_field(idx, COL_PC);
        cause_word = pat_field(idx, COL_CAUSE);
        in_valid   = 1'b1;
        in_insn    = pat_field(idx, COL_INSN);
        in_pc      = pc[31:1];
        in_use_rd  = writes_rd(pat_field(idx, COL_INSN));
        in_rs1_val = pat_field(idx, COL_RS1);
        in_rs2_val = pat_field(idx, COL_RS2);
        in_trap    = pat_field(idx, COL_TRAP) != 32'd0;
        in_cause   = cause_word[3:0];
    endtask

    task automatic check_result(input int idx);
        logic [31:0] exp_val;
        logic [31:0] exp_pc;
        logic        exp_trap;
        logic [31:0] cause_word;
        logic [3:0]  exp_cause;
        logic        exp_use_rd;
        logic        ok;
        ok = 1'b1;
        if (idx >= NUM_TESTS) begin
            $display("Unexpected output after the last test at %0t", $time);
            errors++;
        end else begin
            exp_val    = pat_field(idx, COL_RD);
            exp_pc     = pat_field(idx, COL_PC);
            exp_trap   = pat_field(idx, COL_EXP_TRAP) != 32'd0;
            cause_word = pat_field(idx, COL_EXP_CAUSE);
            exp_cause  = cause_word[3:0];
            exp_use_rd = writes_rd(pat_field(idx, COL_INSN));
            assert (out_rd_val == exp_val) else begin
                $display("Mismatch at %0t: test %0d rd_val %h, expected %h",
                         $time, idx, out_rd_val, exp_val);
                ok = 1'b0;
            end
            assert (out_trap == exp_trap && out_cause == exp_cause) else begin
                $display("Mismatch at %0t: test %0d trap %b cause %0d, expected %b cause %0d",
                         $time, idx, out_trap, out_cause, exp_trap, exp_cause);
                ok = 1'b0;
            end
            assert (out_pc == exp_pc[31:1] && out_insn == pat_field(idx, COL_INSN)) else begin
                $display("Mismatch at %0t: test %0d pc %h insn %h out of order",
                         $time, idx, {out_pc, 1'b0}, out_insn);
                ok = 1'b0;
            end
            assert (out_use_rd == exp_use_rd) else begin
                $display("Mismatch at %0t: test %0d use_rd %b, expected %b",
                         $time, idx, out_use_rd, exp_use_rd);
                ok = 1'b0;
            end
            if (ok) begin
                passed++;
            end else begin
                failed++;
            end
            $display("Test %0d insn %h: %s", idx, pat_field(idx, COL_INSN), ok ? "ok" : "failed");
        end
    endtask

    // Random ready, one LFSR bit per cycle.
    always @(negedge clk) begin
        dbus_ready = lfsr[0];
        lfsr = lfsr_next(lfsr);
    end

    // Word-wide memory, read data returned the cycle after ready.
    assign dbus_rdata = rdata_q;

    always @(posedge clk) begin
        if (!rst && dbus_ready && (dbus_re || dbus_we != 4'b0000)) begin
            bus_count++;
            if (dbus_re) begin
                rdata_q <= mem[dbus_addr[5:0]];
            end
            for (int b = 0; b < 4; b++) begin
                if (dbus_we[b]) begin
                    mem[dbus_addr[5:0]][b*8 +: 8] <= dbus_wdata[b*8 +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            check_result(results_seen);
            results_seen++;
        end
    end

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_insn    = '0;
        in_use_rd  = 1'b0;
        in_rs1_val = '0;
        in_rs2_val = '0;
        in_trap    = 1'b0;
        in_cause   = '0;
        $readmemh(PATTERN_FILE, pat);
        for (int w = 0; w < 64; w++) begin
            mem[w] = w * 32'h0101_0101 ^ 32'hA5A5_A5A5;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            drive_item(i);
            // Hold the item until a cycle without stall.
            #1;
            while (busy) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        wait (results_seen == NUM_TESTS);
        repeat (3) @(negedge clk);
        assert (bus_count == expected_requests()) else begin
            $display("Mismatch at %0t: %0d bus requests, expected %0d",
                     $time, bus_count, expected_requests());
            errors++;
        end
        assert (u_dut.u_checker.fail_count == 0) else begin
            $display("Protocol checker flagged %0d assertion failures",
                     u_dut.u_checker.fail_count);
            errors++;
        end
        $display("Summary: %0d passed, %0d failed, %0d other errors", passed, failed, errors);
        if (passed == NUM_TESTS && failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog, 40 cycles per test plus reset.
    initial begin
        repeat (NUM_TESTS * 40 + 8) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", results_seen, NUM_TESTS);
        $display("RESULT: FAIL");
        $finish;
    end
endmodule

//--- verif/mem_stage_patterns.hex
// insn pc rs1 rs2 in_trap in_cause | expected: rd_val trap cause
// Memory word i starts as {4{i ^ A5}}; rs1 is the byte address or the CSR source.
00052283 00001000 00000004 00000000 0 0 A4A4A4A4 0 0
00050283 00001004 00000000 00000000 0 0 FFFFFFA5 0 0
00054283 00001008 00000001 00000000 0 0 000000A5 0 0
00051283 0000100C 0000000A 00000000 0 0 FFFFA7A7 0 0
00055283 00001010 00000008 00000000 0 0 0000A7A7 0 0
00B52023 00001014 00000040 12345678 0 0 00000040 0 0
00B50023 00001018 00000041 000000AB 0 0 00000041 0 0
00B51023 0000101C 00000042 0000CDEF 0 0 00000042 0 0
00052283 00001020 00000040 00000000 0 0 CDEFAB78 0 0
00050283 00001024 00000041 00000000 0 0 FFFFFFAB 0 0
00054283 00001028 00000040 00000000 0 0 00000078 0 0
00051283 0000102C 00000042 00000000 0 0 FFFFCDEF 0 0
00055283 00001030 00000040 00000000 0 0 0000AB78 0 0
00051283 00001034 00000041 00000000 0 0 00000041 1 4
00052283 00001038 00000042 00000000 0 0 00000042 1 4
00B52023 0000103C 00000043 11111111 0 0 00000043 1 6
00B51023 00001040 00000045 22222222 0 0 00000045 1 6
340512F3 00001044 0F0F0000 00000000 0 0 00000000 0 0
340522F3 00001048 000000F0 00000000 0 0 0F0F0000 0 0
340532F3 0000104C 0F000000 00000000 0 0 0F0F00F0 0 0
340022F3 00001050 FFFFFFFF 00000000 0 0 000F00F0 0 0
340FD2F3 00001054 00000000 00000000 0 0 000F00F0 0 0
3402F2F3 00001058 00000000 00000000 0 0 0000001F 0 0
3401E2F3 0000105C 00000000 00000000 0 0 0000001A 0 0
340022F3 00001060 00000000 00000000 0 0 0000001B 0 0
301022F3 00001064 00000000 00000000 0 0 40000100 0 0
301512F3 00001068 12345678 00000000 0 0 40000100 1 2
7C0022F3 0000106C 00000000 00000000 0 0 00000000 1 2
00052283 00001070 00000040 00000000 1 1 00000040 1 1
00B52023 00001074 00000040 DEADBEEF 1 3 00000040 1 3
340512F3 00001078 FFFFFFFF 00000000 1 B 0000001B 1 B
00052283 0000107C 00000040 00000000 0 0 CDEFAB78 0 0
340022F3 00001080 00000000 00000000 0 0 0000001B 0 0
00B502B3 00001084 CAFEF00D 00000001 0 0 CAFEF00D 0 0

//--- vlog.f
+incdir+hw
hw/mem_stage_pkg.sv
hw/mem_stage_ifc.sv
hw/mem_decode.sv
hw/mem_access.sv
hw/csr_file.sv
hw/mem_result.sv
hw/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/mem_stage_tb.sv

//--- Makefile
# Verilator flow for the memory stage; override any variable on the command line.
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
RTL_TOP   ?= mem_stage_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
